// File: verilog.f
src/csr_pkg.sv
src/csr_seq_ctrl.sv
src/csr_regfile.sv
src/csr_stage.sv
tb/csr_stage_chk.sv
tb/csr_stage_tb.sv

// File: Bender.yml
package:
  name: csr_stage

dependencies: {}

sources:
  - src/csr_pkg.sv
  - src/csr_seq_ctrl.sv
  - src/csr_regfile.sv
  - src/csr_stage.sv

  - target: test
    files:
      - tb/csr_stage_chk.sv
      - tb/csr_stage_tb.sv

// File: tb/csr_stage_tb.sv
`timescale 1ns/1ns

module csr_stage_tb
    import csr_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    // 33 tests of 2 cycles plus 8 reset cycles
    // Limit leaves a wide margin
    localparam int MAX_CYCLES  = 400;

    logic clk, rst_n, csr_valid;
    csr_req_t csr_req;
    mtime_t mtime, mtimecmp;
    xlen_t csr_rdata, csr_trap_vector;
    logic csr_trap_flg, csr_stall_flg;
    priv_mode_e priv_mode;

    // Reference model state
    priv_mode_e m_mode, m_mpp;
    logic m_mie, m_mpie, m_mtie, m_mtip;
    xlen_t m_mtvec, m_mscratch, m_mepc, m_mcause, exp_rdata, exp_vec;

    logic [31:0] lfsr_state = 32'd98;
    inst_id_t next_id = '0;
    int cycles = 0;
    int n_pass = 0;
    int n_fail = 0;
    logic test_bad;

    csr_stage u_csr_stage (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic xlen_t rand_word();
        xlen_t v;
        v = '0;
        for (int i = 0; i < XLEN; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic xlen_t model_read(input csr_addr_t a);
        xlen_t v;
        v = '0;
        case (a)
            ADDR_MSTATUS: begin
                v[MSTATUS_MIE_BIT] = m_mie;
                v[MSTATUS_MPIE_BIT] = m_mpie;
                v[MSTATUS_MPP_LSB +: 2] = m_mpp;
            end
            ADDR_MISA:     v = MISA_VALUE;
            ADDR_MIE:      v[MIE_MTIE_BIT] = m_mtie;
            ADDR_MTVEC:    v = m_mtvec;
            ADDR_MSCRATCH: v = m_mscratch;
            ADDR_MEPC:     v = m_mepc;
            ADDR_MCAUSE:   v = m_mcause;
            ADDR_MIP:      v[MIP_MTIP_BIT] = m_mtip;
            default:       v = '0;
        endcase
        return v;
    endfunction

    // Applies one instruction to the model
    // hit carries mtime >= mtimecmp
    task automatic model_step(input csr_req_t r, input logic hit, output logic trap);
        logic irq, ok, wr;
        xlen_t rv, wv, base;
        irq = m_mtip && m_mie && m_mtie;
        trap = irq || (r.cmd == CSR_ECALL) || (r.cmd == CSR_MRET);
        base = {m_mtvec[XLEN-1:2], 2'b00};
        if (irq) begin
            m_mcause = CAUSE_M_TIMER_IRQ;
            m_mepc = r.pc;
            m_mpp = m_mode;
            m_mpie = m_mie;
            m_mie = 1'b0;
            m_mode = PRIV_M;
            // Vectored mode adds 4 * 7
            exp_vec = (m_mtvec[1:0] == 2'b00) ? base : base + 32'd28;
        end else if (r.cmd != CSR_X) begin
            m_mtip = hit;
            rv = model_read(r.addr);
            ok = (r.addr[9:8] <= m_mode);
            exp_rdata = ok ? rv : '0;
            wr = ok && (r.addr[11:10] != 2'b11) && (r.cmd inside {CSR_W, CSR_S, CSR_C});
            wv = (r.cmd == CSR_W) ? r.op1 : (r.cmd == CSR_S) ? (rv | r.op1) : (rv & ~r.op1);
            if (wr) begin
                case (r.addr)
                    ADDR_MSTATUS: begin
                        m_mie = wv[MSTATUS_MIE_BIT];
                        m_mpie = wv[MSTATUS_MPIE_BIT];
                        m_mpp = (wv[MSTATUS_MPP_LSB +: 2] == 2'b11) ? PRIV_M : PRIV_U;
                    end
                    ADDR_MIE:      m_mtie = wv[MIE_MTIE_BIT];
                    ADDR_MTVEC:    m_mtvec = wv;
                    ADDR_MSCRATCH: m_mscratch = wv;
                    ADDR_MEPC:     m_mepc = {wv[XLEN-1:2], 2'b00};
                    ADDR_MCAUSE:   m_mcause = wv;
                    default: ;
                endcase
            end
            if (r.cmd == CSR_ECALL) begin
                m_mcause = (m_mode == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
                m_mode = PRIV_M;
                exp_vec = base;
            end else if (r.cmd == CSR_MRET) begin
                m_mie = m_mpie;
                m_mpie = 1'b1;
                m_mode = m_mpp;
                m_mpp = PRIV_U;
                exp_vec = m_mepc;
            end
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input xlen_t expected, input xlen_t actual);
        assert (actual === expected) else begin
            $display("FAIL %0s %0s expected %h actual %h", name, what, expected, actual);
            test_bad = 1'b1;
        end
    endtask

    // One instruction over its first cycle and its held cycle
    task automatic run_test(input string name, input csr_cmd_e cmd, input csr_addr_t addr,
                            input xlen_t op1, input xlen_t pc);
        logic exp_stall;
        logic exp_trap;
        test_bad = 1'b0;
        next_id++;
        csr_req.pc = pc;
        csr_req.cmd = cmd;
        csr_req.op1 = op1;
        csr_req.addr = addr;
        csr_req.inst_id = next_id;
        csr_valid = 1'b1;
        exp_stall = (cmd != CSR_X) || (m_mtip && m_mie && m_mtie);
        @(negedge clk);
        model_step(csr_req, (mtime >= mtimecmp), exp_trap);
        check_value(name, "stall", exp_stall, csr_stall_flg);
        check_value(name, "trap", exp_trap, csr_trap_flg);
        @(posedge clk);
        #DRIVE_DELAY;
        @(negedge clk);
        check_value(name, "held stall", '0, csr_stall_flg);
        check_value(name, "rdata", exp_rdata, csr_rdata);
        check_value(name, "vector", exp_vec, csr_trap_vector);
        check_value(name, "priv", m_mode, priv_mode);
        @(posedge clk);
        #DRIVE_DELAY;
        if (test_bad) begin
            n_fail++;
            $display("test %0s: mismatch", name);
        end else begin
            n_pass++;
            $display("test %0s: ok", name);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        csr_valid = 1'b0;
        csr_req = '0;
        mtime = 64'd0;
        mtimecmp = 64'd1000;
        m_mode = PRIV_M;
        m_mpp = PRIV_M;
        {m_mie, m_mpie, m_mtie, m_mtip} = '0;
        {m_mtvec, m_mscratch, m_mepc, m_mcause, exp_rdata, exp_vec} = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Write, set and clear with random operands
        run_test("mscratch_w", CSR_W, ADDR_MSCRATCH, rand_word(), 32'h100);
        run_test("mscratch_s", CSR_S, ADDR_MSCRATCH, rand_word(), 32'h104);
        run_test("mscratch_c", CSR_C, ADDR_MSCRATCH, rand_word(), 32'h108);
        run_test("mscratch_rd", CSR_S, ADDR_MSCRATCH, '0, 32'h10c);
        run_test("mtvec_w", CSR_W, ADDR_MTVEC, rand_word(), 32'h110);
        run_test("mtvec_s", CSR_S, ADDR_MTVEC, rand_word(), 32'h114);
        run_test("mtvec_c", CSR_C, ADDR_MTVEC, rand_word(), 32'h118);
        run_test("mtvec_rd", CSR_S, ADDR_MTVEC, '0, 32'h11c);
        run_test("misa_rd", CSR_S, ADDR_MISA, '0, 32'h120);
        run_test("misa_w", CSR_W, ADDR_MISA, rand_word(), 32'h124);
        run_test("misa_rd2", CSR_S, ADDR_MISA, '0, 32'h128);
        // No CSR work and no interrupt means no stall
        run_test("nop_no_stall", CSR_X, '0, '0, 32'h12c);

        // Machine mode ECALL and MRET
        run_test("ecall_m", CSR_ECALL, '0, '0, 32'h200);
        run_test("mcause_ecall_m", CSR_S, ADDR_MCAUSE, '0, 32'h204);
        run_test("mepc_w", CSR_W, ADDR_MEPC, rand_word(), 32'h208);
        run_test("mpp_m_w", CSR_W, ADDR_MSTATUS, 32'h0000_1800, 32'h20c);
        run_test("mret_m", CSR_MRET, '0, '0, 32'h210);

        // Drop to user mode and probe the privilege check
        run_test("mpp_u_w", CSR_W, ADDR_MSTATUS, 32'h0000_0000, 32'h300);
        run_test("mret_to_u", CSR_MRET, '0, '0, 32'h304);
        run_test("u_mscratch_w", CSR_W, ADDR_MSCRATCH, rand_word(), 32'h308);
        run_test("u_mscratch_rd", CSR_S, ADDR_MSCRATCH, '0, 32'h30c);
        run_test("ecall_u", CSR_ECALL, '0, '0, 32'h310);
        run_test("mcause_ecall_u", CSR_S, ADDR_MCAUSE, '0, 32'h314);
        run_test("mscratch_kept", CSR_S, ADDR_MSCRATCH, '0, 32'h318);

        // Timer interrupt through a vectored mtvec
        run_test("mtvec_vec_w", CSR_W, ADDR_MTVEC, 32'h0000_1001, 32'h400);
        run_test("mtie_w", CSR_W, ADDR_MIE, 32'h0000_0080, 32'h404);
        run_test("mie_w", CSR_W, ADDR_MSTATUS, 32'h0000_1808, 32'h408);
        run_test("timer_idle", CSR_S, ADDR_MSCRATCH, '0, 32'h40c);
        mtime = 64'd2000;
        // This access samples the comparator
        run_test("timer_sample", CSR_S, ADDR_MSCRATCH, '0, 32'h410);
        run_test("timer_irq", CSR_X, '0, '0, 32'h0000_2468);
        run_test("mcause_irq", CSR_S, ADDR_MCAUSE, '0, 32'h418);
        run_test("mepc_irq", CSR_S, ADDR_MEPC, '0, 32'h41c);
        run_test("mie_cleared", CSR_S, ADDR_MSTATUS, '0, 32'h420);

        csr_valid = 1'b0;
        $display("passed %0d, failed %0d, assertion errors %0d",
                 n_pass, n_fail, u_csr_stage.u_chk.n_errors);
        if (n_fail == 0 && u_csr_stage.u_chk.n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tb/csr_stage_chk.sv
`timescale 1ns/1ns

module csr_stage_chk
    import csr_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       csr_valid,
    input csr_req_t   csr_req,
    input logic       csr_trap_flg,
    input logic       csr_stall_flg,
    input priv_mode_e priv_mode
);

    // Failed assertion count
    int n_errors = 0;

    // Traps only ever come with a valid instruction
    a_trap_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) csr_trap_flg |-> csr_valid
    ) else begin
        $error("csr_trap_flg high while csr_valid is low");
        n_errors++;
    end

    // Same for the stall
    a_stall_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) csr_stall_flg |-> csr_valid
    ) else begin
        $error("csr_stall_flg high while csr_valid is low");
        n_errors++;
    end

    // Held copy of a stalled instruction passes
    a_one_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (csr_stall_flg ##1 (csr_valid && $stable(csr_req.inst_id))) |-> !csr_stall_flg
    ) else begin
        $error("instruction stalled twice with the same inst_id");
        n_errors++;
    end

    // Only U and M exist
    a_priv_legal: assert property (
        @(posedge clk) disable iff (!rst_n) priv_mode inside {PRIV_U, PRIV_M}
    ) else begin
        $error("priv_mode holds an unsupported mode");
        n_errors++;
    end

endmodule

bind csr_stage csr_stage_chk u_chk (.*);

// File: src/csr_stage.sv
`timescale 1ns/1ns

module csr_stage
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       csr_valid,
    input  csr_req_t   csr_req,
    input  mtime_t     mtime,
    input  mtime_t     mtimecmp,
    output xlen_t      csr_rdata,
    output xlen_t      csr_trap_vector,
    output logic       csr_trap_flg,
    output logic       csr_stall_flg,
    output priv_mode_e priv_mode
);

    trap_kind_e trap_kind;
    logic       irq_pending;

    // Trap decision and stall generation
    csr_seq_ctrl u_seq_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .cmd         (csr_req.cmd),
        .inst_id     (csr_req.inst_id),
        .irq_pending (irq_pending),
        .trap_kind   (trap_kind),
        .trap_flg    (csr_trap_flg),
        .stall_flg   (csr_stall_flg)
    );

    // Register file acts once per instruction, in its first (stalled) cycle
    // Held cycle only presents the registered results
    csr_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_stall_flg),
        .csr_req     (csr_req),
        .trap_kind   (trap_kind),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .irq_pending (irq_pending),
        .rdata       (csr_rdata),
        .trap_vector (csr_trap_vector),
        .priv_mode   (priv_mode)
    );

endmodule

// File: src/csr_regfile.sv
`timescale 1ns/1ns

module csr_regfile
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       csr_valid,
    input  csr_req_t   csr_req,
    input  trap_kind_e trap_kind,
    input  mtime_t     mtime,
    input  mtime_t     mtimecmp,
    output logic       irq_pending,
    output xlen_t      rdata,
    output xlen_t      trap_vector,
    output priv_mode_e priv_mode
);

    // Current privilege
    priv_mode_e mode;

    // mstatus fields
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_e mstatus_mpp;

    // Timer enable and pending
    logic       mie_mtie;
    logic       mip_mtip;

    // Full-width machine CSRs
    xlen_t      mtvec;
    xlen_t      mscratch;
    xlen_t      mepc;
    xlen_t      mcause;

    csr_addr_t  addr;
    xlen_t      rd_val;
    xlen_t      wdata;
    logic       priv_ok;
    logic       can_write;
    logic       is_write_cmd;
    logic       wr_en;
    logic       timer_hit;
    xlen_t      mtvec_base;
    xlen_t      irq_vector;

    assign addr      = csr_req.addr;
    assign priv_mode = mode;

    // Privilege field of the address must not exceed the mode
    assign priv_ok   = (addr[9:8] <= mode);
    // Top two address bits set means read-only block
    assign can_write = priv_ok && (addr[11:10] != 2'b11);

    // Timer interrupt armed
    assign irq_pending = mip_mtip && mstatus_mie && mie_mtie;
    assign timer_hit   = (mtime >= mtimecmp);

    // Direct mode jumps to base, vectored adds 4 * cause
    assign mtvec_base = {mtvec[XLEN-1:2], 2'b00};
    assign irq_vector = (mtvec[1:0] == 2'b00) ? mtvec_base :
                        mtvec_base + {CAUSE_M_TIMER_IRQ[XLEN-3:0], 2'b00};

    // Current value of the addressed CSR
    always_comb begin
        rd_val = '0;
        case (addr)
            ADDR_MSTATUS: begin
                rd_val[MSTATUS_MIE_BIT]               = mstatus_mie;
                rd_val[MSTATUS_MPIE_BIT]              = mstatus_mpie;
                rd_val[MSTATUS_MPP_LSB +: 2]          = mstatus_mpp;
            end
            ADDR_MISA:     rd_val = MISA_VALUE;
            ADDR_MIE:      rd_val[MIE_MTIE_BIT] = mie_mtie;
            ADDR_MTVEC:    rd_val = mtvec;
            ADDR_MSCRATCH: rd_val = mscratch;
            ADDR_MEPC:     rd_val = mepc;
            ADDR_MCAUSE:   rd_val = mcause;
            ADDR_MIP:      rd_val[MIP_MTIP_BIT] = mip_mtip;
            // Unimplemented addresses read zero
            default:       rd_val = '0;
        endcase
    end

    // Write, set and clear work on the live register value
    always_comb begin
        case (csr_req.cmd)
            CSR_W:   wdata = csr_req.op1;
            CSR_S:   wdata = rd_val | csr_req.op1;
            CSR_C:   wdata = rd_val & ~csr_req.op1;
            default: wdata = rd_val;
        endcase
    end

    assign is_write_cmd = (csr_req.cmd == CSR_W) || (csr_req.cmd == CSR_S) ||
                          (csr_req.cmd == CSR_C);

    // No CSR access in a cycle that takes an interrupt
    assign wr_en = csr_valid && (trap_kind != TRAP_IRQ) && is_write_cmd && can_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode         <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_M;
            mie_mtie     <= 1'b0;
            mip_mtip     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            rdata        <= '0;
            trap_vector  <= '0;
        end else if (csr_valid) begin
            if (trap_kind == TRAP_IRQ) begin
                // Timer interrupt into M-mode
                mcause       <= CAUSE_M_TIMER_IRQ;
                mepc         <= csr_req.pc;
                mstatus_mpp  <= mode;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mode         <= PRIV_M;
                trap_vector  <= irq_vector;
            end else begin
                // Sample the comparator while no interrupt is taken
                mip_mtip <= timer_hit;
                rdata    <= priv_ok ? rd_val : '0;

                if (wr_en) begin
                    case (addr)
                        ADDR_MSTATUS: begin
                            mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                            mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                            // Only U and M exist, anything else maps to U
                            mstatus_mpp  <= (wdata[MSTATUS_MPP_LSB +: 2] == PRIV_M) ?
                                            PRIV_M : PRIV_U;
                        end
                        ADDR_MIE:      mie_mtie <= wdata[MIE_MTIE_BIT];
                        ADDR_MTVEC:    mtvec    <= wdata;
                        ADDR_MSCRATCH: mscratch <= wdata;
                        ADDR_MEPC:     mepc     <= {wdata[XLEN-1:2], 2'b00};
                        ADDR_MCAUSE:   mcause   <= wdata;
                        // misa and mip ignore writes
                        default: ;
                    endcase
                end

                case (trap_kind)
                    TRAP_ECALL: begin
                        // Cause depends on the calling mode, mepc untouched
                        mcause      <= (mode == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
                        mode        <= PRIV_M;
                        trap_vector <= mtvec_base;
                    end
                    TRAP_MRET: begin
                        mstatus_mie  <= mstatus_mpie;
                        mstatus_mpie <= 1'b1;
                        mode         <= mstatus_mpp;
                        mstatus_mpp  <= PRIV_U;
                        trap_vector  <= mepc;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: src/csr_seq_ctrl.sv
`timescale 1ns/1ns

module csr_seq_ctrl
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       csr_valid,
    input  csr_cmd_e   cmd,
    input  inst_id_t   inst_id,
    input  logic       irq_pending,
    output trap_kind_e trap_kind,
    output logic       trap_flg,
    output logic       stall_flg
);

    // Id of the instruction seen in the last valid cycle
    inst_id_t saved_id;
    logic     new_inst;
    logic     needs_stage;

    // Trap priority: interrupt first, then ECALL / MRET
    always_comb begin
        trap_kind = TRAP_NONE;
        if (csr_valid) begin
            if (irq_pending) begin
                // Taken regardless of the command in flight
                trap_kind = TRAP_IRQ;
            end else begin
                case (cmd)
                    CSR_ECALL: trap_kind = TRAP_ECALL;
                    CSR_MRET:  trap_kind = TRAP_MRET;
                    default:   trap_kind = TRAP_NONE;
                endcase
            end
        end
    end

    assign trap_flg = (trap_kind != TRAP_NONE);

    // Saved id tracks every valid cycle, holds otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saved_id <= INST_ID_RESET;
        end else if (csr_valid) begin
            saved_id <= inst_id;
        end
    end

    // First cycle of an instruction carries a new id
    assign new_inst = (inst_id != saved_id);

    // Only real CSR work or a pending interrupt costs a cycle
    assign needs_stage = (cmd != CSR_X) || irq_pending;

    // One stall per instruction, held copy passes through
    assign stall_flg = csr_valid && needs_stage && new_inst;

endmodule

// File: src/csr_pkg.sv
package csr_pkg;

    // Data word width
    localparam int XLEN = 32;

    // Meaningful vector types
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [63:0]     inst_id_t;
    typedef logic [63:0]     mtime_t;

    // Privilege modes, only U and M implemented
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_e;

    // CSR commands from decode
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Trap taken in the current valid cycle
    typedef enum logic [1:0] {
        TRAP_NONE  = 2'd0,
        TRAP_IRQ   = 2'd1,
        TRAP_ECALL = 2'd2,
        TRAP_MRET  = 2'd3
    } trap_kind_e;

    // One CSR instruction as handed over by the previous stage
    typedef struct packed {
        xlen_t     pc;
        csr_cmd_e  cmd;
        xlen_t     op1;      // rs1 value or zimm
        csr_addr_t addr;
        inst_id_t  inst_id;
    } csr_req_t;

    // Machine CSR addresses
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MIP      = 12'h344;

    // mcause codes, top bit marks an interrupt
    localparam xlen_t CAUSE_ECALL_U     = 32'h0000_0008;
    localparam xlen_t CAUSE_ECALL_M     = 32'h0000_000b;
    localparam xlen_t CAUSE_M_TIMER_IRQ = 32'h8000_0007;

    // MXL = 1 (RV32), extensions A, I and M
    localparam xlen_t MISA_VALUE = 32'h4000_1101;

    // Field positions inside mstatus, mie and mip
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIP_MTIP_BIT     = 7;

    // Saved id after reset, never issued by the front end
    localparam inst_id_t INST_ID_RESET = 64'hffff_0000_0000_0000;

endpackage
